// ==== design/autotest_params.svh ====
// ==========================================================================
// width, block size, result base and SPI clock divider macros
// ==========================================================================

`ifndef AUTOTEST_PARAMS_SVH
`define AUTOTEST_PARAMS_SVH

// UUT operand and result widths
`define AT_IN1_W 32
`define AT_IN2_W 32
`define AT_OUT_W 32

// short blocks on the simplified card
`define AT_BLOCK_BYTES 16

// test k writes its result to block AT_RESULT_BASE+k
`define AT_RESULT_BASE 256

// clk cycles per sclk half period, at least 2
`define AT_SCLK_DIV 2

`endif

// ==== design/autotest_pkg.sv ====
// ==========================================================================
// shared vector typedefs and state enums of the self-test harness
// ==========================================================================

`include "autotest_params.svh"

package autotest_pkg;

  typedef logic [`AT_IN1_W-1:0] in1_t;
  typedef logic [`AT_IN2_W-1:0] in2_t;
  typedef logic [`AT_OUT_W-1:0] out_t;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] blk_addr_t;
  typedef logic [7:0]  test_idx_t;
  typedef logic [1:0]  clk_sel_t;
  typedef logic [31:0] debug_t;

  // sequencer states, the code shows up in debug word 2
  typedef enum logic [3:0] {
    ST_HDR_REQ,
    ST_HDR_READ,
    ST_VEC_REQ,
    ST_VEC_READ,
    ST_RUN,
    ST_WR_REQ,
    ST_WR_WAIT,
    ST_DONE
  } fsm_state_t;

  typedef enum logic [3:0] {
    SP_IDLE,
    SP_CMD,
    SP_R1,
    SP_TOKEN,
    SP_RDATA,
    SP_RCRC,
    SP_WTOKEN,
    SP_WDATA,
    SP_WCRC,
    SP_DRESP,
    SP_WBUSY
  } spi_state_t;

endpackage

// ==== design/sd_spi_host.sv ====
// ==========================================================================
// SPI master for SD single-block read (CMD17) and write (CMD24)
// ==========================================================================

`include "autotest_params.svh"

module sd_spi_host import autotest_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      r_block,
  input  logic      w_block,
  input  blk_addr_t block_addr,
  input  byte_t     data_in,
  output byte_t     data_out,
  output logic      byte_valid,
  output logic      byte_req,
  output logic      busy,
  output logic      err,
  output logic      cs,
  output logic      sclk,
  output logic      mosi,
  input  logic      miso
);

  localparam logic [7:0] DIV_LAST  = 8'(`AT_SCLK_DIV - 1);
  // first half period is one cycle short, the launch cycle fills it
  localparam logic [7:0] DIV_START = 8'd1;
  localparam logic [7:0] BLK_LAST  = 8'(`AT_BLOCK_BYTES - 1);
  localparam logic [7:0] POLL_LAST = 8'd63;

  spi_state_t state;
  spi_state_t nxt_state;
  logic       fail;
  blk_addr_t  addr_q;
  logic       is_write;
  logic [7:0] cnt;
  logic       shifting;
  logic [7:0] div_cnt;
  logic [2:0] bit_cnt;
  byte_t      tx_shift;
  byte_t      rx_shift;
  byte_t      tx_byte;
  logic       half_done;
  logic       byte_done;

  assign half_done = shifting && (div_cnt == DIV_LAST);
  // eighth falling edge closes the byte
  assign byte_done = half_done && sclk && (bit_cnt == 3'd7);

  assign mosi       = tx_shift[7];
  assign data_out   = rx_shift;
  assign byte_valid = byte_done && (state == SP_RDATA);
  assign byte_req   = !shifting && (state == SP_WDATA);

  // next byte on the wire
  always_comb begin
    case (state)
      SP_CMD: begin
        case (cnt)
          8'd0:    tx_byte = is_write ? 8'h58 : 8'h51;
          8'd1:    tx_byte = addr_q[31:24];
          8'd2:    tx_byte = addr_q[23:16];
          8'd3:    tx_byte = addr_q[15:8];
          8'd4:    tx_byte = addr_q[7:0];
          // dummy crc
          default: tx_byte = 8'hff;
        endcase
      end
      SP_WTOKEN: tx_byte = 8'hfe;
      SP_WDATA:  tx_byte = data_in;
      default:   tx_byte = 8'hff;
    endcase
  end

  // decided at the end of every byte
  always_comb begin
    nxt_state = state;
    fail      = 1'b0;
    case (state)
      SP_CMD: begin
        if (cnt == 8'd5)
          nxt_state = SP_R1;
      end
      SP_R1: begin
        if (!rx_shift[7]) begin
          nxt_state = is_write ? SP_WTOKEN : SP_TOKEN;
        end else if (cnt == POLL_LAST) begin
          nxt_state = SP_IDLE;
          fail      = 1'b1;
        end
      end
      SP_TOKEN: begin
        if (rx_shift == 8'hfe) begin
          nxt_state = SP_RDATA;
        end else if (cnt == POLL_LAST) begin
          nxt_state = SP_IDLE;
          fail      = 1'b1;
        end
      end
      SP_RDATA: begin
        if (cnt == BLK_LAST)
          nxt_state = SP_RCRC;
      end
      SP_RCRC: begin
        if (cnt == 8'd1)
          nxt_state = SP_IDLE;
      end
      SP_WTOKEN: nxt_state = SP_WDATA;
      SP_WDATA: begin
        if (cnt == BLK_LAST)
          nxt_state = SP_WCRC;
      end
      SP_WCRC: begin
        if (cnt == 8'd1)
          nxt_state = SP_DRESP;
      end
      SP_DRESP: begin
        // data response token is xxx0sss1, accepted = 0x05
        if (rx_shift != 8'hff) begin
          nxt_state = (rx_shift[4:0] == 5'h05) ? SP_WBUSY : SP_IDLE;
          fail      = (rx_shift[4:0] != 5'h05);
        end else if (cnt == POLL_LAST) begin
          nxt_state = SP_IDLE;
          fail      = 1'b1;
        end
      end
      // card holds miso low while programming
      SP_WBUSY: begin
        if (rx_shift != 8'h00)
          nxt_state = SP_IDLE;
      end
      default: nxt_state = state;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= SP_IDLE;
      addr_q   <= '0;
      is_write <= 1'b0;
      cnt      <= '0;
      shifting <= 1'b0;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      tx_shift <= 8'hff;
      rx_shift <= 8'hff;
      sclk     <= 1'b0;
      cs       <= 1'b1;
      busy     <= 1'b0;
      err      <= 1'b0;
    end else begin
      // mode 0 bit engine, sample on rise and shift on fall
      if (shifting) begin
        if (half_done) begin
          div_cnt <= '0;
          sclk    <= !sclk;
          if (!sclk) begin
            rx_shift <= {rx_shift[6:0], miso};
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b1};
            bit_cnt  <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7)
              shifting <= 1'b0;
          end
        end else begin
          div_cnt <= div_cnt + 8'd1;
        end
      end else if (state != SP_IDLE) begin
        shifting <= 1'b1;
        div_cnt  <= DIV_START;
        bit_cnt  <= '0;
        tx_shift <= tx_byte;
      end

      if (state == SP_IDLE) begin
        if (r_block || w_block) begin
          state    <= SP_CMD;
          is_write <= w_block;
          addr_q   <= block_addr;
          cnt      <= '0;
          busy     <= 1'b1;
          cs       <= 1'b0;
          err      <= 1'b0;
        end
      end else if (byte_done) begin
        state <= nxt_state;
        cnt   <= (nxt_state == state) ? cnt + 8'd1 : 8'd0;
        if (nxt_state == SP_IDLE) begin
          busy <= 1'b0;
          cs   <= 1'b1;
          err  <= fail;
        end
      end
    end
  end

  a_one_cmd: assert property (@(posedge clk) disable iff (!rst_n) !(r_block && w_block));
  // requests only land on an idle host
  a_no_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (r_block || w_block) |-> !busy);

endmodule

// ==== design/autotest_fsm.sv ====
// ==========================================================================
// test sequencer: header load, vector read, UUT run, result write back
// and the debug word mux
// ==========================================================================

`include "autotest_params.svh"

module autotest_fsm import autotest_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  output logic       r_block,
  output logic       w_block,
  output blk_addr_t  block_addr,
  input  byte_t      data_out,
  input  logic       byte_valid,
  input  logic       byte_req,
  output byte_t      data_in,
  input  logic       busy,
  input  logic       err,
  output logic       rst_uut,
  input  logic       end_uut,
  output in1_t       in1,
  output in2_t       in2,
  input  out_t       out,
  output clk_sel_t   clk_sel,
  input  logic [1:0] sw_debug,
  output debug_t     debug,
  output logic       done
);

  localparam int IN1_BYTES = `AT_IN1_W / 8;
  localparam int IN2_BYTES = `AT_IN2_W / 8;
  localparam int OUT_BYTES = `AT_OUT_W / 8;

  fsm_state_t state;
  test_idx_t  num_tests;
  test_idx_t  idx;
  out_t       result;
  logic [7:0] byte_cnt;
  logic       end_meta;
  logic       end_sync;
  logic       err_flag;

  // request states last one cycle, the host is idle there
  assign r_block = (state == ST_HDR_REQ) || (state == ST_VEC_REQ);
  assign w_block = (state == ST_WR_REQ);

  always_comb begin
    case (state)
      ST_VEC_REQ: block_addr = blk_addr_t'(idx) + 32'd1;
      ST_WR_REQ:  block_addr = blk_addr_t'(`AT_RESULT_BASE) + blk_addr_t'(idx);
      default:    block_addr = '0;
    endcase
  end

  // result msb first, zero padded to the block end
  always_comb begin
    data_in = '0;
    if (byte_cnt < OUT_BYTES)
      data_in = byte_t'(result >> (8 * (OUT_BYTES - 1 - byte_cnt)));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ST_HDR_REQ;
      num_tests <= '0;
      idx       <= '0;
      clk_sel   <= '0;
      byte_cnt  <= '0;
      end_meta  <= 1'b0;
      end_sync  <= 1'b0;
      rst_uut   <= 1'b1;
      err_flag  <= 1'b0;
      done      <= 1'b0;
    end else begin
      end_meta <= end_uut;
      end_sync <= end_meta;
      case (state)
        ST_HDR_REQ: begin
          byte_cnt <= '0;
          state    <= ST_HDR_READ;
        end
        ST_HDR_READ: begin
          if (byte_valid) begin
            byte_cnt <= byte_cnt + 8'd1;
            if (byte_cnt == 8'd0)
              num_tests <= data_out;
            if (byte_cnt == 8'd1)
              clk_sel <= data_out[1:0];
          end
          if (!busy) begin
            if (err || num_tests == '0) begin
              err_flag <= err;
              done     <= 1'b1;
              state    <= ST_DONE;
            end else begin
              state <= ST_VEC_REQ;
            end
          end
        end
        ST_VEC_REQ: begin
          byte_cnt <= '0;
          state    <= ST_VEC_READ;
        end
        ST_VEC_READ: begin
          if (byte_valid)
            byte_cnt <= byte_cnt + 8'd1;
          if (!busy) begin
            if (err) begin
              err_flag <= 1'b1;
              done     <= 1'b1;
              state    <= ST_DONE;
            end else begin
              rst_uut <= 1'b0;
              state   <= ST_RUN;
            end
          end
        end
        ST_RUN: begin
          if (end_sync) begin
            rst_uut <= 1'b1;
            state   <= ST_WR_REQ;
          end
        end
        ST_WR_REQ: begin
          byte_cnt <= '0;
          state    <= ST_WR_WAIT;
        end
        ST_WR_WAIT: begin
          if (byte_req)
            byte_cnt <= byte_cnt + 8'd1;
          if (!busy) begin
            if (err) begin
              err_flag <= 1'b1;
              done     <= 1'b1;
              state    <= ST_DONE;
            end else begin
              // idx ends at the number of completed tests
              idx <= idx + 8'd1;
              if (idx + 8'd1 == num_tests) begin
                done  <= 1'b1;
                state <= ST_DONE;
              end else begin
                state <= ST_VEC_REQ;
              end
            end
          end
        end
        default: state <= ST_DONE;
      endcase
    end
  end

  // operands and result
  always_ff @(posedge clk) begin
    if (state == ST_VEC_READ && byte_valid) begin
      if (byte_cnt < IN1_BYTES)
        in1 <= {in1[`AT_IN1_W-9:0], data_out};
      else if (byte_cnt < IN1_BYTES + IN2_BYTES)
        in2 <= {in2[`AT_IN2_W-9:0], data_out};
    end
    if (state == ST_RUN && end_sync)
      result <= out;
  end

  always_comb begin
    case (sw_debug)
      2'd0:    debug = {16'h0000, num_tests, idx};
      2'd1:    debug = debug_t'(result);
      // state in 11:8, error flag in bit 1, done in bit 0
      2'd2:    debug = {16'h0000, 4'h0, state, 6'd0, err_flag, done};
      default: debug = debug_t'(in1);
    endcase
  end

  // the UUT leaves reset only while a vector runs
  a_uut_rst: assert property (@(posedge clk) disable iff (!rst_n)
    !rst_uut |-> state == ST_RUN);

endmodule

// ==== design/uut_clk_gen.sv ====
// ==========================================================================
// UUT clock divider: clk/4, clk/2 or clk
// ==========================================================================

module uut_clk_gen import autotest_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  clk_sel_t clk_sel,
  output logic     clk_uut
);

  logic [1:0] div_cnt;
  clk_sel_t   sel_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_cnt <= '0;
      sel_q   <= '0;
    end else begin
      div_cnt <= div_cnt + 2'd1;
      sel_q   <= clk_sel;
    end
  end

  // select is static for a whole run, so a plain mux is enough
  // 1x passes clk, 01 gives clk/2, 00 gives clk/4
  assign clk_uut = sel_q[1] ? clk : (sel_q[0] ? div_cnt[0] : div_cnt[1]);

endmodule

// ==== design/autotest_top.sv ====
// ==========================================================================
// harness top: sequencer, SD SPI host and UUT clock divider
// ==========================================================================

module autotest_top import autotest_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  output logic       cs,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso,
  output logic       rst_uut,
  input  logic       end_uut,
  output in1_t       in1,
  output in2_t       in2,
  input  out_t       out,
  output logic       clk_uut,
  input  logic [1:0] sw_debug,
  output debug_t     debug,
  output logic       done
);

  logic      spi_r_block;
  logic      spi_w_block;
  blk_addr_t spi_block_addr;
  byte_t     spi_data_out;
  byte_t     spi_data_in;
  logic      spi_byte_valid;
  logic      spi_byte_req;
  logic      spi_busy;
  logic      spi_err;
  clk_sel_t  clk_sel;

  autotest_fsm u_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .r_block    (spi_r_block),
    .w_block    (spi_w_block),
    .block_addr (spi_block_addr),
    .data_out   (spi_data_out),
    .byte_valid (spi_byte_valid),
    .byte_req   (spi_byte_req),
    .data_in    (spi_data_in),
    .busy       (spi_busy),
    .err        (spi_err),
    .rst_uut    (rst_uut),
    .end_uut    (end_uut),
    .in1        (in1),
    .in2        (in2),
    .out        (out),
    .clk_sel    (clk_sel),
    .sw_debug   (sw_debug),
    .debug      (debug),
    .done       (done)
  );

  sd_spi_host u_spi (
    .clk        (clk),
    .rst_n      (rst_n),
    .r_block    (spi_r_block),
    .w_block    (spi_w_block),
    .block_addr (spi_block_addr),
    .data_in    (spi_data_in),
    .data_out   (spi_data_out),
    .byte_valid (spi_byte_valid),
    .byte_req   (spi_byte_req),
    .busy       (spi_busy),
    .err        (spi_err),
    .cs         (cs),
    .sclk       (sclk),
    .mosi       (mosi),
    .miso       (miso)
  );

  uut_clk_gen u_clk_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .clk_sel (clk_sel),
    .clk_uut (clk_uut)
  );

endmodule

// ==== tb/tb_clk_gen.sv ====
// ==========================================================================
// testbench clock, 4 ns period, and a reset held low for 16 cycles
// ==========================================================================

module tb_clk_gen (
  input  logic rst_req,
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RST_CYCLES = 16;

  int hold_cnt = RST_CYCLES;

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #2 clk = !clk;
  end

  // a request restarts the hold, release lands 1 ns after an edge
  always @(posedge clk) begin
    if (rst_req)
      hold_cnt = RST_CYCLES;
    else if (hold_cnt > 0)
      hold_cnt = hold_cnt - 1;
    #1;
    rst_n = (hold_cnt == 0);
  end

endmodule

// ==== tb/sd_card_model.sv ====
// ==========================================================================
// behavioral SD card in SPI mode: block memory, CMD17/CMD24 responses,
// load and peek tasks and a switch that withholds the read data token
// ==========================================================================

`include "autotest_params.svh"

module sd_card_model import autotest_pkg::*; (
  input  logic cs,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  input  logic no_token
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_BLKS = 512;
  localparam int M_IDLE   = 0;
  localparam int M_CMD    = 1;
  localparam int M_WTOKEN = 2;
  localparam int M_WDATA  = 3;
  localparam int M_WCRC   = 4;

  byte_t mem [NUM_BLKS][`AT_BLOCK_BYTES];
  byte_t tx_q [$];
  byte_t cmd_buf [6];
  byte_t rx_sr = 8'hff;
  byte_t tx_sr = 8'hff;
  int    bit_cnt = 0;
  int    mode = M_IDLE;
  int    cnt = 0;
  int    cur_blk = 0;
  int    blocks_written = 0;

  assign miso = cs ? 1'b1 : tx_sr[7];

  // every byte of the card gets a value from its full byte address
  task automatic fill_mem();
    int a;
    for (int b = 0; b < NUM_BLKS; b++) begin
      for (int i = 0; i < `AT_BLOCK_BYTES; i++) begin
        a = b * `AT_BLOCK_BYTES + i;
        mem[b][i] = byte_t'(a) ^ byte_t'(a >> 8) ^ 8'h5a;
      end
    end
    blocks_written = 0;
  endtask

  task automatic load_byte(input int blk, input int idx, input byte_t val);
    mem[blk][idx] = val;
  endtask

  task automatic peek_byte(input int blk, input int idx, output byte_t val);
    val = mem[blk][idx];
  endtask

  task automatic handle_byte(input byte_t b);
    logic [31:0] addr;
    case (mode)
      M_IDLE: begin
        if (b[7:6] == 2'b01) begin
          cmd_buf[0] = b;
          cnt = 1;
          mode = M_CMD;
        end
      end
      M_CMD: begin
        cmd_buf[cnt] = b;
        cnt = cnt + 1;
        if (cnt == 6) begin
          addr = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
          cur_blk = int'(addr[8:0]);
          cnt = 0;
          // one byte of Ncr, then R1 ready
          tx_q.push_back(8'hff);
          tx_q.push_back(8'h00);
          if (cmd_buf[0] == 8'h58) begin
            mode = M_WTOKEN;
          end else begin
            mode = M_IDLE;
            if (!no_token) begin
              tx_q.push_back(8'hff);
              tx_q.push_back(8'hfe);
              for (int i = 0; i < `AT_BLOCK_BYTES; i++)
                tx_q.push_back(mem[cur_blk][i]);
              tx_q.push_back(8'hff);
              tx_q.push_back(8'hff);
            end
          end
        end
      end
      M_WTOKEN: begin
        if (b == 8'hfe)
          mode = M_WDATA;
      end
      M_WDATA: begin
        mem[cur_blk][cnt] = b;
        cnt = cnt + 1;
        if (cnt == `AT_BLOCK_BYTES) begin
          cnt = 0;
          mode = M_WCRC;
        end
      end
      M_WCRC: begin
        cnt = cnt + 1;
        if (cnt == 2) begin
          // data accepted, then two busy bytes
          tx_q.push_back(8'h05);
          tx_q.push_back(8'h00);
          tx_q.push_back(8'h00);
          blocks_written = blocks_written + 1;
          cnt = 0;
          mode = M_IDLE;
        end
      end
      default: mode = M_IDLE;
    endcase
  endtask

  // mode 0: mosi sampled on the rise, miso moves on the fall
  always @(posedge sclk or negedge sclk or posedge cs) begin
    if (cs) begin
      bit_cnt = 0;
      cnt = 0;
      mode = M_IDLE;
      tx_sr = 8'hff;
      tx_q.delete();
    end else if (sclk) begin
      rx_sr = {rx_sr[6:0], mosi};
      bit_cnt = bit_cnt + 1;
    end else if (bit_cnt == 8) begin
      handle_byte(rx_sr);
      bit_cnt = 0;
      if (tx_q.size() > 0)
        tx_sr = tx_q.pop_front();
      else
        tx_sr = 8'hff;
    end else begin
      tx_sr = {tx_sr[6:0], 1'b1};
    end
  end

endmodule

// ==== tb/tb_uut_adder.sv ====
// ==========================================================================
// behavioral UUT: 32-bit adder that raises end 3 clocks out of reset
// ==========================================================================

module tb_uut_adder import autotest_pkg::*; (
  input  logic clk_uut,
  input  logic rst_uut,
  input  in1_t in1,
  input  in2_t in2,
  output out_t out,
  output logic end_uut
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int END_DELAY = 3;

  int run_cnt;

  always @(posedge clk_uut) begin
    if (rst_uut) begin
      run_cnt <= 0;
      end_uut <= 1'b0;
      out     <= '0;
    end else begin
      out <= in1 + in2;
      if (run_cnt == END_DELAY - 1)
        end_uut <= 1'b1;
      else
        run_cnt <= run_cnt + 1;
    end
  end

endmodule

// ==== tb/autotest_tb.sv ====
// ==========================================================================
// autotest testbench: run table, card loading, result and debug checks,
// UUT clock rate check and watchdog
// ==========================================================================

`include "autotest_params.svh"

module autotest_tb import autotest_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_RUNS  = 4;
  localparam int MAX_TESTS = 4;
  localparam int WORDS     = `AT_BLOCK_BYTES / 4;
  // twice runs x (tests + 2) x 3 blocks x 40 bytes x 8 bits x 4 clk x 4 ns
  localparam longint WATCHDOG_NS = 2 * NUM_RUNS * (MAX_TESTS + 2) * 3 * 40 * 8 * 4 * 4;

  logic       clk;
  logic       rst_n;
  logic       rst_req;
  logic       cs;
  logic       sclk;
  logic       mosi;
  logic       miso;
  logic       rst_uut;
  logic       end_uut;
  logic       clk_uut;
  logic       done;
  logic       no_token;
  logic [1:0] sw_debug;
  in1_t       in1;
  in2_t       in2;
  out_t       out;
  debug_t     debug;
  int         uut_edges = 0;

  // run table
  clk_sel_t  run_sel [NUM_RUNS];
  logic      run_err [NUM_RUNS];
  test_idx_t run_n   [NUM_RUNS];
  in1_t      run_in1 [NUM_RUNS][MAX_TESTS];
  in2_t      run_in2 [NUM_RUNS][MAX_TESTS];
  out_t      run_exp [NUM_RUNS][MAX_TESTS];

  tb_clk_gen clk_rst (.rst_req(rst_req), .clk(clk), .rst_n(rst_n));

  autotest_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .cs       (cs),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .rst_uut  (rst_uut),
    .end_uut  (end_uut),
    .in1      (in1),
    .in2      (in2),
    .out      (out),
    .clk_uut  (clk_uut),
    .sw_debug (sw_debug),
    .debug    (debug),
    .done     (done)
  );

  sd_card_model card (.cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso), .no_token(no_token));

  tb_uut_adder uut (
    .clk_uut (clk_uut),
    .rst_uut (rst_uut),
    .in1     (in1),
    .in2     (in2),
    .out     (out),
    .end_uut (end_uut)
  );

  always @(posedge clk_uut)
    uut_edges <= uut_edges + 1;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_out(input string name, input out_t got, input out_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_debug(input string name, input debug_t got, input debug_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input test_idx_t got, input test_idx_t exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("mismatch at %0d ns: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  // expect clk/4 for 00, clk/2 for 01 and clk for 1x within one edge
  task automatic check_edge_rate(input int edges, input clk_sel_t sel);
    int exp;
    exp = sel[1] ? 40 : (sel[0] ? 20 : 10);
    if (edges < exp - 1 || edges > exp + 1) begin
      abort_run($sformatf("mismatch at %0d ns: clk_uut edges got %0d expected %0d",
                          $time, edges, exp));
    end
  endtask

  task automatic build_table();
    int seed;
    seed = 40;
    for (int r = 0; r < NUM_RUNS; r++) begin
      for (int k = 0; k < MAX_TESTS; k++) begin
        run_in1[r][k] = '0;
        run_in2[r][k] = '0;
      end
    end
    run_sel[0] = 2'b00;
    run_err[0] = 1'b0;
    run_n[0]   = 8'd3;
    run_in1[0][0] = 32'h0000_0001;
    run_in2[0][0] = 32'h0000_0002;
    run_in1[0][1] = 32'hffff_ffff;
    run_in2[0][1] = 32'h0000_0001;
    run_in1[0][2] = 32'h1234_5678;
    run_in2[0][2] = 32'h0edc_ba98;
    run_sel[1] = 2'b01;
    run_err[1] = 1'b0;
    run_n[1]   = 8'd4;
    for (int k = 0; k < MAX_TESTS; k++) begin
      run_in1[1][k] = in1_t'($random(seed));
      run_in2[1][k] = in2_t'($random(seed));
    end
    run_sel[2] = 2'b10;
    run_err[2] = 1'b0;
    run_n[2]   = 8'd2;
    run_in1[2][0] = 32'h8000_0000;
    run_in2[2][0] = 32'h8000_0000;
    run_in1[2][1] = 32'hdead_beef;
    run_in2[2][1] = 32'h0102_0304;
    // card never sends the read data token
    run_sel[3] = 2'b11;
    run_err[3] = 1'b1;
    run_n[3]   = 8'd2;
    run_in1[3][0] = 32'h0000_0005;
    run_in2[3][0] = 32'h0000_0006;
    run_in1[3][1] = 32'h0000_0007;
    run_in2[3][1] = 32'h0000_0008;
    // sums wrap at 32 bits
    for (int r = 0; r < NUM_RUNS; r++) begin
      for (int k = 0; k < MAX_TESTS; k++)
        run_exp[r][k] = run_in1[r][k] + run_in2[r][k];
    end
  endtask

  function automatic int run_cycles(input int r);
    return 2 * (int'(run_n[r]) + 2) * 3 * 40 * 8 * 4;
  endfunction

  // header in block 0, test k in block k+1, operands msb first
  task automatic load_card(input int r);
    card.fill_mem();
    card.load_byte(0, 0, byte_t'(run_n[r]));
    card.load_byte(0, 1, byte_t'(run_sel[r]));
    for (int k = 0; k < int'(run_n[r]); k++) begin
      for (int j = 0; j < 4; j++) begin
        card.load_byte(k + 1, j, byte_t'(run_in1[r][k] >> (8 * (3 - j))));
        card.load_byte(k + 1, 4 + j, byte_t'(run_in2[r][k] >> (8 * (3 - j))));
      end
    end
  endtask

  task automatic set_debug_sel(input logic [1:0] sel);
    @(posedge clk);
    #1;
    sw_debug = sel;
    @(posedge clk);
    #1;
  endtask

  task automatic wait_uut_run(input int r);
    int cycles;
    cycles = 0;
    while (rst_uut) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > run_cycles(r))
        abort_run("the UUT reset was never released during the run");
    end
  endtask

  task automatic wait_done(input int r);
    int cycles;
    cycles = 0;
    while (!done) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > run_cycles(r))
        abort_run("done did not rise within the expected number of cycles");
    end
  endtask

  task automatic check_results(input int r);
    out_t      word;
    byte_t     b;
    test_idx_t n;
    n = run_n[r];
    for (int k = 0; k < int'(n); k++) begin
      for (int w = 0; w < WORDS; w++) begin
        word = '0;
        for (int j = 0; j < 4; j++) begin
          card.peek_byte(`AT_RESULT_BASE + k, 4 * w + j, b);
          word = {word[23:0], b};
        end
        if (w == 0)
          check_out($sformatf("result block %0d sum", k), word, run_exp[r][k]);
        else
          check_out($sformatf("result block %0d pad word %0d", k, w), word, '0);
      end
    end
    check_count("blocks written", test_idx_t'(card.blocks_written), n);
    set_debug_sel(2'd0);
    check_count("debug test count", test_idx_t'(debug[15:8]), n);
    check_count("debug test index", test_idx_t'(debug[7:0]), n);
    set_debug_sel(2'd1);
    check_debug("debug last result", debug, debug_t'(run_exp[r][int'(n) - 1]));
    set_debug_sel(2'd3);
    check_debug("debug last in1", debug, debug_t'(run_in1[r][int'(n) - 1]));
  endtask

  task automatic check_error_run();
    set_debug_sel(2'd2);
    check_debug("debug error and done bits", debug & 32'h3, 32'h3);
    check_count("blocks written", test_idx_t'(card.blocks_written), 8'd0);
  endtask

  task automatic apply_run(input int r);
    int start_edges;
    @(posedge clk);
    #1;
    sw_debug = 2'd0;
    no_token = run_err[r];
    rst_req  = 1'b1;
    @(posedge clk);
    #1;
    rst_req = 1'b0;
    load_card(r);
    @(posedge rst_n);
    check_level("cs after reset", cs, 1'b1);
    check_level("rst_uut after reset", rst_uut, 1'b1);
    check_level("done after reset", done, 1'b0);
    if (!run_err[r]) begin
      wait_uut_run(r);
      start_edges = uut_edges;
      repeat (40) @(posedge clk);
      #1;
      check_edge_rate(uut_edges - start_edges, run_sel[r]);
    end
    wait_done(r);
    if (run_err[r])
      check_error_run();
    else
      check_results(r);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before all runs finished");
  end

  initial begin
    sw_debug = 2'd0;
    no_token = 1'b0;
    rst_req  = 1'b0;
    build_table();
    for (int r = 0; r < NUM_RUNS; r++)
      apply_run(r);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// ==== autotest.f ====
+incdir+design
design/autotest_pkg.sv
design/sd_spi_host.sv
design/autotest_fsm.sv
design/uut_clk_gen.sv
design/autotest_top.sv
tb/tb_clk_gen.sv
tb/sd_card_model.sv
tb/tb_uut_adder.sv
tb/autotest_tb.sv

// ==== Makefile ====
# Verilator build and run of the autotest testbench

SIM = obj_dir/Vautotest_tb

.PHONY: run clean

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

$(SIM): autotest.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		-f autotest.f --top-module autotest_tb

clean:
	rm -rf obj_dir
